/* source/accel_params.svh */
`ifndef ACCEL_PARAMS_SVH
`define ACCEL_PARAMS_SVH

// one memory line carries eight complex samples packed {imag, real}
`define LINE_W        512
`define SAMPLE_W      64
`define PART_W        32   // real and imaginary parts, both signed
`define LINE_SAMPLES  8

// a block is eight lines, so the input buffer holds 64 samples
`define BLOCK_LINES   8
`define BLOCK_SAMPLES 64

`define ADDR_W        16   // line address, counts whole lines
`define COEF_W        16   // each coefficient part is signed Q1.15

`endif

/* source/accelPkg.sv */
`default_nettype none

`include "accel_params.svh"

package accelPkg;

    // one memory line decoded two ways
    // the raw view is what the memory port and the arbiter move around,
    // the sample view is how the input buffer and the packer see the same bits
    typedef union packed {
        logic [`LINE_W-1:0] raw;
        // sample 0 sits in the low bits, part 0 real and part 1 imaginary
        logic [`LINE_SAMPLES-1:0][1:0][`PART_W-1:0] samples;
    } memLine_u;

endpackage

`default_nettype wire

/* source/lineLoader.sv */
`timescale 1ns/10ps
`default_nettype none

`include "accel_params.svh"

// walks the source block one line at a time
// each line address is held on the request until the arbiter grants it,
// the returned data goes straight to the input buffer and never passes here
module lineLoader (
    input  wire                clk,
    input  wire                rst,
    input  wire                go,       // one cycle, block parameters already latched
    input  wire [`ADDR_W-1:0]  srcBase,  // first line of the source block
    input  wire                ldGrant,  // arbiter took our request this cycle
    output logic               ldReq,
    output logic [`ADDR_W-1:0] ldAddr
);

    localparam int idxW = $clog2(`BLOCK_LINES);

    logic            active;   // still lines left to request
    logic [idxW-1:0] lineIdx;  // offset of the line currently on the request

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            lineIdx <= '0;
        end else if (go) begin
            active  <= 1'b1;  // the top only sends go while idle
            lineIdx <= '0;
        end else if (active && ldGrant) begin
            lineIdx <= lineIdx + 1'b1;  // move on only when granted
            // the eighth grant ends the block
            if (lineIdx == idxW'(`BLOCK_LINES - 1)) begin
                active <= 1'b0;
            end
        end
    end

    // the request is a level that stays up across any cycles lost to the writer
    assign ldReq  = active;
    assign ldAddr = srcBase + {{(`ADDR_W - idxW){1'b0}}, lineIdx};  // base plus line offset

endmodule

`default_nettype wire

/* source/inputBuffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "accel_params.svh"

// collects one block of lines from memory and plays it back
// as a stream of single samples, one per cycle
module inputBuffer import accelPkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 wrEn,          // read data returning from memory
    input  wire memLine_u       dataIn,        // eight samples, sample 0 in the low bits
    output logic                emptyReady,    // block complete, readout in progress
    output logic [`SAMPLE_W-1:0] dataOut,      // one {imag, real} sample
    output logic                dataOutValid
);

    localparam int lineW  = $clog2(`BLOCK_LINES);
    localparam int sampW  = $clog2(`LINE_SAMPLES);
    localparam int depthW = $clog2(`BLOCK_SAMPLES);

    logic [`SAMPLE_W-1:0] storage [`BLOCK_SAMPLES];  // sample storage for one whole block
    logic [lineW-1:0]     fillLine;  // which line of the block arrives next
    logic [depthW-1:0]    outIdx;    // next sample to play back

    // a line lands as eight neighbouring samples, so the sample index is
    // simply the line number with the slot number below it
    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int j = 0; j < `LINE_SAMPLES; j++) begin
                storage[{fillLine, sampW'(j)}] <= dataIn.samples[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fillLine     <= '0;
            outIdx       <= '0;
            emptyReady   <= 1'b0;
            dataOutValid <= 1'b0;
        end else begin
            dataOutValid <= emptyReady;  // the read below takes one cycle
            if (wrEn) begin
                fillLine <= fillLine + 1'b1;  // wraps back to zero after the last line
                if (fillLine == lineW'(`BLOCK_LINES - 1)) begin
                    emptyReady <= 1'b1;  // the eighth line completes the block
                end
            end
            if (emptyReady) begin
                outIdx <= outIdx + 1'b1;
                // outIdx wraps to zero here, which rearms for the next block
                if (outIdx == depthW'(`BLOCK_SAMPLES - 1)) begin
                    emptyReady <= 1'b0;
                end
            end
        end
    end

    // registered read port, follows emptyReady by one cycle
    always_ff @(posedge clk) begin
        if (emptyReady) begin
            dataOut <= storage[outIdx];
        end
    end

endmodule

`default_nettype wire

/* source/complexScaler.sv */
`timescale 1ns/10ps
`default_nettype none

`include "accel_params.svh"

// multiplies each sample by a Q1.15 complex coefficient
// two register stages, a new sample can enter every cycle
module complexScaler (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        inValid,
    input  wire [`SAMPLE_W-1:0]        inSample,  // {imag, real}
    input  wire signed [`COEF_W-1:0]   coefRe,
    input  wire signed [`COEF_W-1:0]   coefIm,
    output logic                       resValid,
    output logic [`SAMPLE_W-1:0]       resOut     // {imag, real}, same packing as the input
);

    localparam int prodW = `PART_W + `COEF_W;  // full width of a 32 by 16 product

    logic signed [`PART_W-1:0] aRe;
    logic signed [`PART_W-1:0] aIm;
    logic signed [prodW-1:0]   pReRe, pImIm, pReIm, pImRe;  // stage 1 products
    logic                      valid1;
    logic signed [prodW:0]     sumRe, sumIm;   // one extra bit so the add cannot wrap
    logic signed [prodW:0]     shRe, shIm;     // back to integer scale

    assign aRe = inSample[`PART_W-1:0];
    assign aIm = inSample[`SAMPLE_W-1:`PART_W];

    // stage 1 registers the four cross products
    always_ff @(posedge clk) begin
        pReRe <= aRe * coefRe;
        pImIm <= aIm * coefIm;
        pReIm <= aRe * coefIm;
        pImRe <= aIm * coefRe;
    end

    // (a.re + j a.im)(c.re + j c.im) with the Q1.15 fraction dropped by an arithmetic shift
    assign sumRe = pReRe - pImIm;
    assign sumIm = pReIm + pImRe;
    assign shRe  = sumRe >>> (`COEF_W - 1);
    assign shIm  = sumIm >>> (`COEF_W - 1);

    // stage 2 truncates each part to 32 bits, the upper bits are simply lost
    always_ff @(posedge clk) begin
        resOut <= {shIm[`PART_W-1:0], shRe[`PART_W-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid1   <= 1'b0;
            resValid <= 1'b0;
        end else begin
            valid1   <= inValid;  // valid walks alongside the data, two cycles in all
            resValid <= valid1;
        end
    end

endmodule

`default_nettype wire

/* source/resultPacker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "accel_params.svh"

// gathers scaled samples into memory lines and writes them back
module resultPacker import accelPkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 go,        // new block, clears the counters
    input  wire [`ADDR_W-1:0]   dstBase,   // first line of the destination block
    input  wire                 resValid,
    input  wire [`SAMPLE_W-1:0] resOut,
    input  wire                 wrGrant,
    output logic                wrReq,     // pending line waiting for the memory port
    output logic [`ADDR_W-1:0]  wrAddr,
    output memLine_u            wrData,
    output logic                done       // one cycle after the last line is granted
);

    localparam int sampW = $clog2(`LINE_SAMPLES);
    localparam int lineW = $clog2(`BLOCK_LINES);

    memLine_u         assembly;  // line being filled
    memLine_u         nextLine;  // assembly with the current result dropped in
    logic [sampW-1:0] sampleIdx; // slot the next result goes into
    logic [lineW-1:0] lineCnt;   // lines moved to the pending register so far
    logic [lineW-1:0] writeCnt;  // lines granted so far
    logic             lineFull;

    always_comb begin
        nextLine = assembly;
        nextLine.samples[sampleIdx] = resOut;
    end

    assign lineFull = resValid && (sampleIdx == sampW'(`LINE_SAMPLES - 1));

    // data path, the pending line is written only when a line completes
    always_ff @(posedge clk) begin
        if (resValid) begin
            assembly <= nextLine;
        end
        if (lineFull) begin
            wrData <= nextLine;
            wrAddr <= dstBase + {{(`ADDR_W - lineW){1'b0}}, lineCnt};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sampleIdx <= '0;
            lineCnt   <= '0;
            writeCnt  <= '0;
            wrReq     <= 1'b0;
            done      <= 1'b0;
        end else if (go) begin
            sampleIdx <= '0;
            lineCnt   <= '0;
            writeCnt  <= '0;
            wrReq     <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= wrReq && wrGrant && (writeCnt == lineW'(`BLOCK_LINES - 1));
            if (resValid) begin
                sampleIdx <= sampleIdx + 1'b1;  // wraps to slot 0 for the next line
            end
            if (lineFull) begin
                lineCnt <= lineCnt + 1'b1;
                wrReq   <= 1'b1;  // writer has priority so this clears a cycle later
            end else if (wrGrant) begin
                wrReq <= 1'b0;
            end
            if (wrReq && wrGrant) begin
                writeCnt <= writeCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/memArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "accel_params.svh"

// shares the single memory port between the result packer and the line loader
// the writer always wins, and the memory never stalls, so grants are
// simply the requests after priority is applied
module memArbiter import accelPkg::*; (
    input  wire                ldReq,
    input  wire [`ADDR_W-1:0]  ldAddr,
    input  wire                wrReq,
    input  wire [`ADDR_W-1:0]  wrAddr,
    input  wire memLine_u      wrData,
    output logic               ldGrant,
    output logic               wrGrant,
    output logic               memReq,
    output logic               memWe,
    output logic [`ADDR_W-1:0] memAddr,
    output memLine_u           memWrData
);

    always_comb begin
        wrGrant = wrReq;             // highest priority, never waits
        ldGrant = ldReq && !wrReq;   // loader only gets the free cycles

        memReq  = wrReq || ldReq;
        memWe   = wrReq;             // only the packer ever writes
        memAddr = wrReq ? wrAddr : ldAddr;

        // write data is only meaningful with memWe, zero keeps the bus quiet on reads
        memWrData.raw = wrReq ? wrData.raw : '0;
    end

    // a pending write blocks the loader for at most one cycle since the
    // packer needs eight results before it can ask again

endmodule

`default_nettype wire

/* source/accelTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "accel_params.svh"

// block scaler with its memory front end
// loader and packer are peers on the one memory port, the sample path runs
// from the input buffer through the scaler into the packer
module accelTop import accelPkg::*; (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,      // one cycle, ignored while busy
    input  wire [`ADDR_W-1:0]         srcBase,
    input  wire [`ADDR_W-1:0]         dstBase,
    input  wire signed [`COEF_W-1:0]  coefRe,
    input  wire signed [`COEF_W-1:0]  coefIm,
    input  wire memLine_u             memRdData,
    input  wire                       memRdValid, // two cycles after the read request
    output logic                      memReq,
    output logic                      memWe,
    output logic [`ADDR_W-1:0]        memAddr,
    output memLine_u                  memWrData,
    output logic                      busy,
    output logic                      done
);

    logic                      busyReg;
    logic                      goPulse;     // first busy cycle, kicks loader and packer
    logic                      startOk;
    logic [`ADDR_W-1:0]        srcBaseReg, dstBaseReg;
    logic signed [`COEF_W-1:0] coefReReg, coefImReg;
    logic                      ldReq, ldGrant, wrReq, wrGrant;
    logic [`ADDR_W-1:0]        ldAddr, wrAddr;
    memLine_u                  wrData;
    logic [`SAMPLE_W-1:0]      sample, result;
    logic                      sampleValid, resultValid;

    assign startOk = start && !busy;
    assign busy    = busyReg && !done;  // busy drops in the same cycle done pulses

    always_ff @(posedge clk) begin
        if (startOk) begin  // command held steady for the whole block
            srcBaseReg <= srcBase;
            dstBaseReg <= dstBase;
            coefReReg  <= coefRe;
            coefImReg  <= coefIm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busyReg <= 1'b0;
            goPulse <= 1'b0;
        end else begin
            goPulse <= startOk;
            if (startOk) busyReg <= 1'b1;  // a start in the done cycle wins over the clear
            else if (done) busyReg <= 1'b0;
        end
    end

    lineLoader u_lineLoader (.clk(clk), .rst(rst), .go(goPulse), .srcBase(srcBaseReg),
        .ldGrant(ldGrant), .ldReq(ldReq), .ldAddr(ldAddr));

    // only the loader reads, so returning data needs no steering
    inputBuffer u_inputBuffer (.clk(clk), .rst(rst), .wrEn(memRdValid), .dataIn(memRdData),
        .emptyReady(), .dataOut(sample), .dataOutValid(sampleValid));

    complexScaler u_complexScaler (.clk(clk), .rst(rst), .inValid(sampleValid),
        .inSample(sample), .coefRe(coefReReg), .coefIm(coefImReg),
        .resValid(resultValid), .resOut(result));

    resultPacker u_resultPacker (.clk(clk), .rst(rst), .go(goPulse), .dstBase(dstBaseReg),
        .resValid(resultValid), .resOut(result), .wrGrant(wrGrant), .wrReq(wrReq),
        .wrAddr(wrAddr), .wrData(wrData), .done(done));

    memArbiter u_memArbiter (.ldReq(ldReq), .ldAddr(ldAddr), .wrReq(wrReq), .wrAddr(wrAddr),
        .wrData(wrData), .ldGrant(ldGrant), .wrGrant(wrGrant), .memReq(memReq),
        .memWe(memWe), .memAddr(memAddr), .memWrData(memWrData));

endmodule

`default_nettype wire

/* sim/accelTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "accel_params.svh"

module accelTb import accelPkg::*; ;

    localparam int maxCycles = 400;  // two blocks of roughly 100 cycles each plus idle gaps

    logic clk = 1'b0;
    logic rst, start, memRdValid, memReq, memWe, busy, done;
    logic [`ADDR_W-1:0] srcBase, dstBase, memAddr;
    logic signed [`COEF_W-1:0] coefRe, coefIm;
    memLine_u memRdData, memWrData;

    logic [`LINE_W-1:0] lineMem [logic [`ADDR_W-1:0]];  // sparse model of host memory
    logic               reqPend, pipeValid;   // read return pipeline, two cycles deep
    logic [`ADDR_W-1:0] reqAddr, pipeAddr;
    logic [31:0]        lfsrState;
    logic               blockActive;          // set after start, cleared by the done pulse
    logic [`ADDR_W-1:0] curSrc, curDst;
    logic signed [`COEF_W-1:0] curRe, curIm;
    logic [`LINE_W-1:0] expLine;
    int rdIdx, wrIdx, doneCount, checkCount, errCount, cycleCount;

    accelTop u_accelTop (.clk(clk), .rst(rst), .start(start), .srcBase(srcBase),
        .dstBase(dstBase), .coefRe(coefRe), .coefIm(coefIm), .memRdData(memRdData),
        .memRdValid(memRdValid), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
        .memWrData(memWrData), .busy(busy), .done(done));

    always #2 clk = ~clk;

    // taps 32, 22, 2, 1 give a maximal length sequence
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one complex sample times the Q1.15 coefficient, fraction dropped, parts cut to 32 bits
    function automatic logic [`SAMPLE_W-1:0] expScale(input logic [`SAMPLE_W-1:0] s,
            input logic signed [`COEF_W-1:0] cRe, input logic signed [`COEF_W-1:0] cIm);
        longint aRe, aIm, re, im;
        aRe = longint'(signed'(s[`PART_W-1:0]));
        aIm = longint'(signed'(s[`SAMPLE_W-1:`PART_W]));
        re  = (aRe * longint'(cRe) - aIm * longint'(cIm)) >>> (`COEF_W - 1);
        im  = (aRe * longint'(cIm) + aIm * longint'(cRe)) >>> (`COEF_W - 1);
        return {im[`PART_W-1:0], re[`PART_W-1:0]};
    endfunction

    function automatic logic [`LINE_W-1:0] scaleLine(input logic [`LINE_W-1:0] src,
            input logic signed [`COEF_W-1:0] cRe, input logic signed [`COEF_W-1:0] cIm);
        logic [`LINE_W-1:0] res;
        for (int j = 0; j < `LINE_SAMPLES; j++) begin
            res[j*`SAMPLE_W +: `SAMPLE_W] = expScale(src[j*`SAMPLE_W +: `SAMPLE_W], cRe, cIm);
        end
        return res;
    endfunction

    // source lines get fresh random bits, the LFSR steps once per bit
    task automatic fillSource(input logic [`ADDR_W-1:0] base);
        logic [`LINE_W-1:0] line;
        for (int l = 0; l < `BLOCK_LINES; l++) begin
            for (int b = 0; b < `LINE_W; b++) begin
                lfsrState = lfsrNext(lfsrState);
                line[b]   = lfsrState[0];
            end
            lineMem[base + `ADDR_W'(l)] = line;
        end
    endtask

    // memory samples requests mid cycle and answers reads two cycles later
    always @(negedge clk) begin
        reqPend = memReq && !memWe;
        reqAddr = memAddr;
        if (memReq && memWe) lineMem[memAddr] = memWrData.raw;  // record every write
    end

    always @(posedge clk) begin
        #1;
        memRdValid    = pipeValid;
        memRdData.raw = (pipeValid && lineMem.exists(pipeAddr)) ? lineMem[pipeAddr] : '0;
        pipeValid     = reqPend;
        pipeAddr      = reqAddr;
    end

    // compares every request against the block that is expected to be running
    always @(negedge clk) begin
        if (!rst) begin
            checkCount++;
            if (busy !== (blockActive && !done)) begin
                errCount++;
                $display("Error busy: expected %h, actual %h", blockActive && !done, busy);
            end
            if (memReq && !memWe) begin
                if (!blockActive || rdIdx >= `BLOCK_LINES) begin
                    errCount++;
                    $display("read request outside the eight reads of a running block");
                end else if (memAddr !== curSrc + `ADDR_W'(rdIdx)) begin
                    errCount++;
                    $display("Error memAddr read %0d: expected %h, actual %h", rdIdx,
                        curSrc + `ADDR_W'(rdIdx), memAddr);
                end
                rdIdx++;
            end
            if (memReq && memWe) begin
                if (!blockActive || wrIdx >= `BLOCK_LINES) begin
                    errCount++;
                    $display("write request outside the eight writes of a running block");
                end else begin
                    if (memAddr !== curDst + `ADDR_W'(wrIdx)) begin
                        errCount++;
                        $display("Error memAddr write %0d: expected %h, actual %h", wrIdx,
                            curDst + `ADDR_W'(wrIdx), memAddr);
                    end
                    expLine = scaleLine(lineMem[curSrc + `ADDR_W'(wrIdx)], curRe, curIm);
                    if (memWrData.raw !== expLine) begin
                        errCount++;
                        $display("Error wrData line %0d: expected %h, actual %h", wrIdx,
                            expLine, memWrData.raw);
                    end
                end
                wrIdx++;
            end
            if (done) begin
                if (!blockActive || wrIdx != `BLOCK_LINES || rdIdx != `BLOCK_LINES) begin
                    errCount++;
                    $display("done pulsed outside a block or before all eight writes");
                end
                doneCount++;
                blockActive = 1'b0;  // busy must be low from here on
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount == maxCycles) begin
            $display("run did not finish within %0d cycles", maxCycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic runBlock(input logic [`ADDR_W-1:0] src, input logic [`ADDR_W-1:0] dst,
            input logic signed [`COEF_W-1:0] cRe, input logic signed [`COEF_W-1:0] cIm,
            input bit extraStart);
        @(posedge clk);
        #1;
        srcBase = src;
        dstBase = dst;
        coefRe  = cRe;
        coefIm  = cIm;
        start   = 1'b1;
        curSrc  = src;
        curDst  = dst;
        curRe   = cRe;
        curIm   = cIm;
        rdIdx   = 0;
        wrIdx   = 0;
        @(posedge clk);
        #1;
        start       = 1'b0;
        blockActive = 1'b1;
        if (extraStart) begin  // a second command mid block must leave no trace
            repeat (20) @(posedge clk);
            #1;
            srcBase = 16'h0300;
            dstBase = 16'h0400;
            coefRe  = 16'sh7fff;
            start   = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        while (blockActive) @(posedge clk);
        if (rdIdx != `BLOCK_LINES || wrIdx != `BLOCK_LINES) begin
            errCount++;
            $display("block ended after %0d reads and %0d writes instead of eight each",
                rdIdx, wrIdx);
        end
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        srcBase = '0;
        dstBase = '0;
        coefRe = '0;
        coefIm = '0;
        memRdValid = 1'b0;
        memRdData = '0;
        reqPend = 1'b0;
        pipeValid = 1'b0;
        reqAddr = '0;
        pipeAddr = '0;
        blockActive = 1'b0;
        rdIdx = 0;
        wrIdx = 0;
        doneCount = 0;
        checkCount = 0;
        errCount = 0;
        cycleCount = 0;
        lfsrState = 32'h638f_24e6;
        fillSource(16'h0100);
        fillSource(16'h1230);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (5) @(posedge clk);  // idle, nothing may move before the first start
        runBlock(16'h0100, 16'h0200, 16'sh4000, 16'sh2d41, 1'b1);
        repeat (10) @(posedge clk);
        runBlock(16'h1230, 16'h0ff8, -16'sd12000, 16'sh8000, 1'b0);  // both parts negative
        repeat (5) @(posedge clk);
        if (doneCount != 2) begin
            errCount++;
            $display("saw %0d done pulses for two blocks", doneCount);
        end
        $display("checks %0d, errors %0d, done pulses %0d", checkCount, errCount, doneCount);
        if (errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/accelPkg.sv
source/lineLoader.sv
source/inputBuffer.sv
source/complexScaler.sv
source/resultPacker.sv
source/memArbiter.sv
source/accelTop.sv
sim/accelTb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module accelTb -f vlog.f -o accelSim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/accelSim > sim.log 2>&1 && cat sim.log || { cat sim.log; echo "run failed"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "no pass message in log"; exit 1; }
exit 0
